// ==== build.f ====
+incdir+.
router_stats_pkg.sv
port_stats_bank.sv
stats_csr_file.sv
router_stats_top.sv
router_stats_tb.sv

// ==== port_stats_bank.sv ====
////////////////////
// Port statistics bank
// Drop counting and per-port snapshots for one direction
////////////////////

`timescale 1ns/1ps

`include "router_stats_cfg.svh"

module port_stats_bank (
    input  logic                                clk_ifc,
    input  logic                                peripheral_sresetn_core,
    input  router_stats_pkg::port_mask_t        sample_req,
    input  router_stats_pkg::port_mask_t        buf_full_drop,
    input  router_stats_pkg::live_cnts_t        live_cnts [`ROUTER_STATS_NUM_PORTS],
    input  logic [2:0]                          rd_port,
    input  router_stats_pkg::cnt_slot_e         rd_slot,
    output logic [`ROUTER_STATS_DATA_WIDTH-1:0] rd_word
);

    ////////////////////
    // Edge detection
    ////////////////////

    router_stats_pkg::port_mask_t sample_q;
    router_stats_pkg::port_mask_t sample_qq;
    router_stats_pkg::port_mask_t drop_q;
    router_stats_pkg::port_mask_t drop_qq;
    router_stats_pkg::port_mask_t sample_rise;
    router_stats_pkg::port_mask_t drop_rise;

    // Snapshot storage and running drop counts
    router_stats_pkg::snapshot_t        snap [`ROUTER_STATS_NUM_PORTS];
    logic [`ROUTER_STATS_CNT_WIDTH-1:0] drop_cnt [`ROUTER_STATS_NUM_PORTS];

    assign sample_rise = sample_q & ~sample_qq;
    assign drop_rise   = drop_q & ~drop_qq;

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_q  <= '0;
            sample_qq <= '0;
            drop_q    <= '0;
            drop_qq   <= '0;
        end else begin
            sample_q  <= sample_req;
            sample_qq <= sample_q;
            drop_q    <= buf_full_drop;
            drop_qq   <= drop_q;
        end
    end

    ////////////////////
    // Drop counters and snapshots
    ////////////////////

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            for (int p = 0; p < `ROUTER_STATS_NUM_PORTS; p++) begin
                snap[p]     <= '0;
                drop_cnt[p] <= '0;
            end
        end else begin
            for (int p = 0; p < `ROUTER_STATS_NUM_PORTS; p++) begin
                if (sample_rise[p]) begin
                    snap[p].pkt   <= live_cnts[p].pkt_cnt;
                    snap[p].bytes <= live_cnts[p].byte_cnt;
                    snap[p].err   <= live_cnts[p].err_cnt;
                    // Count before this cycle's edge goes into the snapshot
                    snap[p].drop  <= drop_cnt[p];
                    drop_cnt[p]   <= {{(`ROUTER_STATS_CNT_WIDTH-1){1'b0}}, drop_rise[p]};
                end else if (drop_rise[p]) begin
                    drop_cnt[p] <= drop_cnt[p] + 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Read port
    ////////////////////

    always_comb begin
        case (rd_slot)
            router_stats_pkg::SLOT_PKT:  rd_word = snap[rd_port].pkt;
            router_stats_pkg::SLOT_BYTE: rd_word = snap[rd_port].bytes;
            router_stats_pkg::SLOT_ERR:  rd_word = snap[rd_port].err;
            router_stats_pkg::SLOT_DROP: rd_word = snap[rd_port].drop;
            default:                     rd_word = '0;
        endcase
    end

    // Slot index from the register file must always be a known value
    a_rd_slot_known: assert property (
        @(posedge clk_ifc) disable iff (!peripheral_sresetn_core)
        !$isunknown(rd_slot)
    ) else $error("port_stats_bank: rd_slot is not a defined slot");

endmodule

// ==== router_stats_cfg.svh ====
////////////////////
// Router statistics block configuration
// Widths, port count, identity and register indices
////////////////////

`ifndef ROUTER_STATS_CFG_SVH
`define ROUTER_STATS_CFG_SVH

// Sizes
`define ROUTER_STATS_NUM_PORTS      8
`define ROUTER_STATS_CNT_WIDTH      32
`define ROUTER_STATS_DATA_WIDTH     32
`define ROUTER_STATS_ADDR_WIDTH     7

// Identity word contents
`define ROUTER_STATS_MODULE_ID      16'd10
`define ROUTER_STATS_MODULE_VERSION 16'h0100

// Control region word indices
`define REG_VERSION_ID              7'd0
`define REG_ING_PORT_ENABLE_CON     7'd1
`define REG_EGR_PORT_ENABLE_CON     7'd2
`define REG_ING_PORT_ENABLE_STAT    7'd3
`define REG_EGR_PORT_ENABLE_STAT    7'd4
`define REG_ING_COUNTER_CON         7'd5
`define REG_EGR_COUNTER_CON         7'd6

// Address regions
`define REGION_CTRL                 2'd0
`define REGION_ING                  2'd1
`define REGION_EGR                  2'd2

`endif

// ==== router_stats_pkg.sv ====
////////////////////
// Router statistics types
// Bus structs, address union and counter records
////////////////////

`include "router_stats_cfg.svh"

package router_stats_pkg;

    // One bit per physical port
    typedef logic [`ROUTER_STATS_NUM_PORTS-1:0] port_mask_t;

    // Counter slot within a port
    typedef enum logic [1:0] {
        SLOT_PKT  = 2'd0,
        SLOT_BYTE = 2'd1,
        SLOT_ERR  = 2'd2,
        SLOT_DROP = 2'd3
    } cnt_slot_e;

    // Counter view of a word address
    typedef struct packed {
        logic [1:0] region;
        logic [2:0] port;
        cnt_slot_e  slot;
    } cnt_addr_t;

    // Same word seen flat or split into region, port and slot
    typedef union packed {
        logic [`ROUTER_STATS_ADDR_WIDTH-1:0] raw;
        cnt_addr_t                           cnt;
    } stats_addr_u;

    typedef struct packed {
        logic                                wr_en;
        logic                                rd_en;
        stats_addr_u                         addr;
        logic [`ROUTER_STATS_DATA_WIDTH-1:0] wdata;
    } csr_req_t;

    typedef struct packed {
        logic                                rd_valid;
        logic                                rd_error;
        logic [`ROUTER_STATS_DATA_WIDTH-1:0] rd_data;
    } csr_rsp_t;

    // Live counters from the datapath
    typedef struct packed {
        logic [`ROUTER_STATS_CNT_WIDTH-1:0] pkt_cnt;
        logic [`ROUTER_STATS_CNT_WIDTH-1:0] byte_cnt;
        logic [`ROUTER_STATS_CNT_WIDTH-1:0] err_cnt;
    } live_cnts_t;

    typedef struct packed {
        logic [`ROUTER_STATS_CNT_WIDTH-1:0] pkt;
        logic [`ROUTER_STATS_CNT_WIDTH-1:0] bytes;
        logic [`ROUTER_STATS_CNT_WIDTH-1:0] err;
        logic [`ROUTER_STATS_CNT_WIDTH-1:0] drop;
    } snapshot_t;

endpackage

// ==== router_stats_tb.sv ====
////////////////////
// Router statistics testbench
// Register, snapshot and drop-count checks against a shadow model
////////////////////

`timescale 1ns/1ps

`include "router_stats_cfg.svh"

module router_stats_tb;

    localparam int NP         = `ROUTER_STATS_NUM_PORTS;
    localparam int RD_TIMEOUT = 20;

    logic                         clk_ifc;
    logic                         peripheral_sresetn_core;
    router_stats_pkg::csr_req_t   csr_req;
    router_stats_pkg::csr_rsp_t   csr_rsp;
    router_stats_pkg::live_cnts_t ing_live_cnts [NP];
    router_stats_pkg::live_cnts_t egr_live_cnts [NP];
    router_stats_pkg::port_mask_t ing_buf_full_drop;
    router_stats_pkg::port_mask_t egr_buf_full_drop;
    router_stats_pkg::port_mask_t ing_phys_ports_enable;
    router_stats_pkg::port_mask_t egr_phys_ports_enable;

    // Shadow state with index 0 for ingress and 1 for egress
    router_stats_pkg::port_mask_t en_con [2];
    router_stats_pkg::port_mask_t cnt_con [2];
    router_stats_pkg::snapshot_t  snap [2][NP];
    logic [31:0]                  drops [2][NP];

    integer seed;
    int     errors;
    int     test_mark;
    int     tests_passed;
    int     tests_failed;

    initial begin
        clk_ifc = 1'b0;
        forever #2 clk_ifc = ~clk_ifc;
    end

    router_stats_top i_dut (
        .clk_ifc                 (clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .csr_req                 (csr_req),
        .ing_live_cnts           (ing_live_cnts),
        .egr_live_cnts           (egr_live_cnts),
        .ing_buf_full_drop       (ing_buf_full_drop),
        .egr_buf_full_drop       (egr_buf_full_drop),
        .csr_rsp                 (csr_rsp),
        .ing_phys_ports_enable   (ing_phys_ports_enable),
        .egr_phys_ports_enable   (egr_phys_ports_enable)
    );

    ////////////////////
    // Reference model
    ////////////////////

    // Returns {rd_error, rd_data} for a word address
    function automatic logic [32:0] expected_read(input logic [6:0] addr);
        router_stats_pkg::snapshot_t s;
        logic [31:0]                 data;
        logic                        err;
        data = '0;
        err  = 1'b0;
        s    = snap[addr[6:5] == 2'd2 ? 1 : 0][addr[4:2]];
        case (addr[6:5])
            2'd0: begin
                case (addr)
                    // Version 1.0 in the upper half and ID 10 in the lower half
                    `REG_VERSION_ID:
                        data = {16'h0100, 16'd10};
                    `REG_ING_PORT_ENABLE_CON, `REG_ING_PORT_ENABLE_STAT: data = {24'd0, en_con[0]};
                    `REG_EGR_PORT_ENABLE_CON, `REG_EGR_PORT_ENABLE_STAT: data = {24'd0, en_con[1]};
                    `REG_ING_COUNTER_CON: data = {24'd0, cnt_con[0]};
                    `REG_EGR_COUNTER_CON: data = {24'd0, cnt_con[1]};
                    default:              err = 1'b1;
                endcase
            end
            2'd3: err = 1'b1;
            default: begin
                case (addr[1:0])
                    2'd0:    data = s.pkt;
                    2'd1:    data = s.bytes;
                    2'd2:    data = s.err;
                    default: data = s.drop;
                endcase
            end
        endcase
        return {err, data};
    endfunction

    // Ports whose bit rises take a snapshot and restart their drop count
    function automatic void apply_sample(input int d, input router_stats_pkg::port_mask_t mask);
        router_stats_pkg::live_cnts_t lc;
        for (int p = 0; p < NP; p++) begin
            lc = (d == 0) ? ing_live_cnts[p] : egr_live_cnts[p];
            if (mask[p] && !cnt_con[d][p]) begin
                snap[d][p] = {lc.pkt_cnt, lc.byte_cnt, lc.err_cnt, drops[d][p]};
                drops[d][p] = '0;
            end
        end
        cnt_con[d] = mask;
    endfunction

    ////////////////////
    // Bus and datapath tasks
    ////////////////////

    task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
        @(negedge clk_ifc);
        csr_req.wr_en    = 1'b1;
        csr_req.addr.raw = addr;
        csr_req.wdata    = data;
        @(negedge clk_ifc);
        csr_req.wr_en = 1'b0;
        case (addr)
            `REG_ING_PORT_ENABLE_CON: en_con[0] = data[NP-1:0];
            `REG_EGR_PORT_ENABLE_CON: en_con[1] = data[NP-1:0];
            `REG_ING_COUNTER_CON:     apply_sample(0, data[NP-1:0]);
            `REG_EGR_COUNTER_CON:     apply_sample(1, data[NP-1:0]);
            default: ;
        endcase
        // Snapshot lands two edges after the write
        if (addr == `REG_ING_COUNTER_CON || addr == `REG_EGR_COUNTER_CON) begin
            repeat (3) @(negedge clk_ifc);
        end
    endtask

    task automatic read_check(input logic [6:0] addr);
        logic [32:0] exp;
        int          n;
        exp = expected_read(addr);
        @(negedge clk_ifc);
        csr_req.rd_en    = 1'b1;
        csr_req.addr.raw = addr;
        @(negedge clk_ifc);
        csr_req.rd_en = 1'b0;
        n = 0;
        while (!csr_rsp.rd_valid && n < RD_TIMEOUT) begin
            @(negedge clk_ifc);
            n++;
        end
        if (!csr_rsp.rd_valid) begin
            $display("Read of address %0d got no rd_valid within %0d cycles", addr, RD_TIMEOUT);
            errors++;
        end else begin
            if (csr_rsp.rd_data !== exp[31:0]) begin
                $display("FAIL t=%0t rd_data addr=%0d expected=%h actual=%h",
                         $time, addr, exp[31:0], csr_rsp.rd_data);
                errors++;
            end
            if (csr_rsp.rd_error !== exp[32]) begin
                $display("FAIL t=%0t rd_error addr=%0d expected=%b actual=%b",
                         $time, addr, exp[32], csr_rsp.rd_error);
                errors++;
            end
        end
    endtask

    task automatic read_range(input int first, input int count);
        for (int a = first; a < first + count; a++) begin
            read_check(a[6:0]);
        end
    endtask

    task automatic check_enables();
        @(negedge clk_ifc);
        if (ing_phys_ports_enable !== en_con[0]) begin
            $display("FAIL t=%0t ing_phys_ports_enable expected=%h actual=%h",
                     $time, en_con[0], ing_phys_ports_enable);
            errors++;
        end
        if (egr_phys_ports_enable !== en_con[1]) begin
            $display("FAIL t=%0t egr_phys_ports_enable expected=%h actual=%h",
                     $time, en_con[1], egr_phys_ports_enable);
            errors++;
        end
    endtask

    task automatic randomize_live(input int d);
        router_stats_pkg::live_cnts_t lc;
        @(negedge clk_ifc);
        for (int p = 0; p < NP; p++) begin
            lc = {$random(seed), $random(seed), $random(seed)};
            if (d == 0) ing_live_cnts[p] = lc;
            else        egr_live_cnts[p] = lc;
        end
    endtask

    // One cycle high, then low long enough for the edge to be counted
    task automatic drop_pulse(input int d, input int p);
        @(negedge clk_ifc);
        if (d == 0) ing_buf_full_drop[p] = 1'b1;
        else        egr_buf_full_drop[p] = 1'b1;
        @(negedge clk_ifc);
        if (d == 0) ing_buf_full_drop[p] = 1'b0;
        else        egr_buf_full_drop[p] = 1'b0;
        repeat (2) @(negedge clk_ifc);
        drops[d][p] = drops[d][p] + 1;
    endtask

    task automatic end_test(input string name);
        if (errors == test_mark) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, errors - test_mark);
            tests_failed++;
        end
        test_mark = errors;
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        logic [6:0]  con_addr;
        logic [31:0] mask;
        seed = 32'h3d0f99ba;
        {errors, test_mark, tests_passed, tests_failed} = '0;
        peripheral_sresetn_core = 1'b0;
        csr_req           = '0;
        ing_buf_full_drop = '0;
        egr_buf_full_drop = '0;
        for (int p = 0; p < NP; p++) begin
            ing_live_cnts[p] = '0;
            egr_live_cnts[p] = '0;
            for (int d = 0; d < 2; d++) begin
                snap[d][p]  = '0;
                drops[d][p] = '0;
            end
        end
        en_con  = '{default: '1};
        cnt_con = '{default: '0};
        repeat (8) @(posedge clk_ifc);
        @(negedge clk_ifc);
        peripheral_sresetn_core = 1'b1;

        read_range(0, 7);
        check_enables();
        read_range(32, 64);
        end_test("reset_values");

        for (int i = 0; i < 24; i++) begin
            case ($random(seed) & 3)
                0:       con_addr = `REG_ING_PORT_ENABLE_CON;
                1:       con_addr = `REG_EGR_PORT_ENABLE_CON;
                2:       con_addr = `REG_ING_COUNTER_CON;
                default: con_addr = `REG_EGR_COUNTER_CON;
            endcase
            write_reg(con_addr, $random(seed));
            read_range(1, 6);
            check_enables();
        end
        // Read-only and counter words ignore writes
        write_reg(`REG_VERSION_ID, $random(seed));
        write_reg(`REG_ING_PORT_ENABLE_STAT, $random(seed));
        write_reg(`REG_EGR_PORT_ENABLE_STAT, $random(seed));
        write_reg(7'h25, $random(seed));
        write_reg(7'h4a, $random(seed));
        read_range(0, 7);
        read_check(7'h25);
        read_check(7'h4a);
        end_test("control_writes");

        read_range(7, 25);
        read_range(96, 32);
        read_range(0, 7);
        end_test("unmapped_reads");

        for (int d = 0; d < 2; d++) begin
            con_addr = (d == 0) ? `REG_ING_COUNTER_CON : `REG_EGR_COUNTER_CON;
            write_reg(con_addr, 32'd0);
            randomize_live(d);
            mask = $random(seed);
            write_reg(con_addr, mask);
            read_range(32 + 32 * d, 32);
            randomize_live(d);
            write_reg(con_addr, mask);
            read_range(32 + 32 * d, 32);
        end
        end_test("counter_snapshot");

        for (int d = 0; d < 2; d++) begin
            con_addr = (d == 0) ? `REG_ING_COUNTER_CON : `REG_EGR_COUNTER_CON;
            write_reg(con_addr, 32'd0);
            for (int p = 0; p < NP; p++) begin
                repeat (p + 1) drop_pulse(d, p);
            end
            write_reg(con_addr, 32'hff);
            read_range(32 + 32 * d, 32);
            write_reg(con_addr, 32'd0);
            write_reg(con_addr, 32'hff);
            read_range(32 + 32 * d, 32);
        end
        end_test("drop_counting");

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== router_stats_top.sv ====
////////////////////
// Router statistics block
////////////////////

`timescale 1ns/1ps

`include "router_stats_cfg.svh"

module router_stats_top (
    input  logic                         clk_ifc,
    input  logic                         peripheral_sresetn_core,
    input  router_stats_pkg::csr_req_t   csr_req,
    input  router_stats_pkg::live_cnts_t ing_live_cnts [`ROUTER_STATS_NUM_PORTS],
    input  router_stats_pkg::live_cnts_t egr_live_cnts [`ROUTER_STATS_NUM_PORTS],
    input  router_stats_pkg::port_mask_t ing_buf_full_drop,
    input  router_stats_pkg::port_mask_t egr_buf_full_drop,
    output router_stats_pkg::csr_rsp_t   csr_rsp,
    output router_stats_pkg::port_mask_t ing_phys_ports_enable,
    output router_stats_pkg::port_mask_t egr_phys_ports_enable
);

    router_stats_pkg::port_mask_t        ing_sample_req;
    router_stats_pkg::port_mask_t        egr_sample_req;
    logic [`ROUTER_STATS_DATA_WIDTH-1:0] ing_rd_word;
    logic [`ROUTER_STATS_DATA_WIDTH-1:0] egr_rd_word;
    logic [2:0]                          rd_port;
    router_stats_pkg::cnt_slot_e         rd_slot;

    stats_csr_file i_csr (
        .clk_ifc                 (clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .csr_req                 (csr_req),
        .ing_rd_word             (ing_rd_word),
        .egr_rd_word             (egr_rd_word),
        .csr_rsp                 (csr_rsp),
        .ing_sample_req          (ing_sample_req),
        .egr_sample_req          (egr_sample_req),
        .ing_phys_ports_enable   (ing_phys_ports_enable),
        .egr_phys_ports_enable   (egr_phys_ports_enable),
        .rd_port                 (rd_port),
        .rd_slot                 (rd_slot)
    );

    // Both banks share the read index, the register file picks the region
    port_stats_bank i_ing_bank (
        .clk_ifc                 (clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .sample_req              (ing_sample_req),
        .buf_full_drop           (ing_buf_full_drop),
        .live_cnts               (ing_live_cnts),
        .rd_port                 (rd_port),
        .rd_slot                 (rd_slot),
        .rd_word                 (ing_rd_word)
    );

    port_stats_bank i_egr_bank (
        .clk_ifc                 (clk_ifc),
        .peripheral_sresetn_core (peripheral_sresetn_core),
        .sample_req              (egr_sample_req),
        .buf_full_drop           (egr_buf_full_drop),
        .live_cnts               (egr_live_cnts),
        .rd_port                 (rd_port),
        .rd_slot                 (rd_slot),
        .rd_word                 (egr_rd_word)
    );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the router statistics testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module router_stats_tb -f build.f -o router_stats_sim

out=$(./obj_dir/router_stats_sim) || true
echo "$out"

if echo "$out" | grep -qF -- '** PASS **'; then
    exit 0
fi
exit 1

// ==== stats_csr_file.sv ====
////////////////////
// Statistics register file
// Control registers, address decode and read response
////////////////////

`timescale 1ns/1ps

`include "router_stats_cfg.svh"

module stats_csr_file (
    input  logic                                clk_ifc,
    input  logic                                peripheral_sresetn_core,
    input  router_stats_pkg::csr_req_t          csr_req,
    input  logic [`ROUTER_STATS_DATA_WIDTH-1:0] ing_rd_word,
    input  logic [`ROUTER_STATS_DATA_WIDTH-1:0] egr_rd_word,
    output router_stats_pkg::csr_rsp_t          csr_rsp,
    output router_stats_pkg::port_mask_t        ing_sample_req,
    output router_stats_pkg::port_mask_t        egr_sample_req,
    output router_stats_pkg::port_mask_t        ing_phys_ports_enable,
    output router_stats_pkg::port_mask_t        egr_phys_ports_enable,
    output logic [2:0]                          rd_port,
    output router_stats_pkg::cnt_slot_e         rd_slot
);

    localparam logic [`ROUTER_STATS_DATA_WIDTH-1:0] VERSION_ID_WORD =
        {`ROUTER_STATS_MODULE_VERSION, `ROUTER_STATS_MODULE_ID};

    // Port masks sit in the low bits of a bus word
    function automatic logic [`ROUTER_STATS_DATA_WIDTH-1:0] mask_word(
        input router_stats_pkg::port_mask_t mask
    );
        return {{(`ROUTER_STATS_DATA_WIDTH-`ROUTER_STATS_NUM_PORTS){1'b0}}, mask};
    endfunction

    ////////////////////
    // Control registers
    ////////////////////

    router_stats_pkg::port_mask_t ing_en_con;
    router_stats_pkg::port_mask_t egr_en_con;
    router_stats_pkg::port_mask_t ing_en_stat;
    router_stats_pkg::port_mask_t egr_en_stat;
    router_stats_pkg::port_mask_t ing_cnt_con;
    router_stats_pkg::port_mask_t egr_cnt_con;

    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_en_con  <= '1;
            egr_en_con  <= '1;
            ing_en_stat <= '1;
            egr_en_stat <= '1;
            ing_cnt_con <= '0;
            egr_cnt_con <= '0;
        end else begin
            ing_en_stat <= ing_en_con;
            egr_en_stat <= egr_en_con;
            // Raw index only matches in the control region
            if (csr_req.wr_en) begin
                case (csr_req.addr.raw)
                    `REG_ING_PORT_ENABLE_CON:
                        ing_en_con <= csr_req.wdata[`ROUTER_STATS_NUM_PORTS-1:0];
                    `REG_EGR_PORT_ENABLE_CON:
                        egr_en_con <= csr_req.wdata[`ROUTER_STATS_NUM_PORTS-1:0];
                    `REG_ING_COUNTER_CON:
                        ing_cnt_con <= csr_req.wdata[`ROUTER_STATS_NUM_PORTS-1:0];
                    `REG_EGR_COUNTER_CON:
                        egr_cnt_con <= csr_req.wdata[`ROUTER_STATS_NUM_PORTS-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign ing_phys_ports_enable = ing_en_con;
    assign egr_phys_ports_enable = egr_en_con;
    assign ing_sample_req        = ing_cnt_con;
    assign egr_sample_req        = egr_cnt_con;

    ////////////////////
    // Read path
    ////////////////////

    logic                                rd_pend;
    router_stats_pkg::stats_addr_u       rd_addr_q;
    logic [`ROUTER_STATS_DATA_WIDTH-1:0] rd_data_nxt;
    logic                                rd_error_nxt;
    logic                                rd_valid_q;
    logic                                rd_error_q;
    logic [`ROUTER_STATS_DATA_WIDTH-1:0] rd_data_q;

    // First stage holds the request
    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            rd_pend   <= 1'b0;
            rd_addr_q <= '0;
        end else begin
            rd_pend <= csr_req.rd_en;
            if (csr_req.rd_en) begin
                rd_addr_q <= csr_req.addr;
            end
        end
    end

    // Banks index with the counter view of the held address
    assign rd_port = rd_addr_q.cnt.port;
    assign rd_slot = rd_addr_q.cnt.slot;

    always_comb begin
        rd_data_nxt  = '0;
        rd_error_nxt = 1'b0;
        case (rd_addr_q.cnt.region)
            `REGION_CTRL: begin
                case (rd_addr_q.raw)
                    `REG_VERSION_ID:           rd_data_nxt = VERSION_ID_WORD;
                    `REG_ING_PORT_ENABLE_CON:  rd_data_nxt = mask_word(ing_en_con);
                    `REG_EGR_PORT_ENABLE_CON:  rd_data_nxt = mask_word(egr_en_con);
                    `REG_ING_PORT_ENABLE_STAT: rd_data_nxt = mask_word(ing_en_stat);
                    `REG_EGR_PORT_ENABLE_STAT: rd_data_nxt = mask_word(egr_en_stat);
                    `REG_ING_COUNTER_CON:      rd_data_nxt = mask_word(ing_cnt_con);
                    `REG_EGR_COUNTER_CON:      rd_data_nxt = mask_word(egr_cnt_con);
                    default:                   rd_error_nxt = 1'b1;
                endcase
            end
            `REGION_ING: rd_data_nxt = ing_rd_word;
            `REGION_EGR: rd_data_nxt = egr_rd_word;
            default:     rd_error_nxt = 1'b1;
        endcase
    end

    // Second stage is the response
    always_ff @(posedge clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_pend;
        end
    end

    always_ff @(posedge clk_ifc) begin
        if (rd_pend) begin
            rd_data_q  <= rd_data_nxt;
            rd_error_q <= rd_error_nxt;
        end
    end

    always_comb begin
        csr_rsp.rd_valid = rd_valid_q;
        csr_rsp.rd_error = rd_error_q;
        csr_rsp.rd_data  = rd_data_q;
    end

    a_no_rd_wr_overlap: assert property (
        @(posedge clk_ifc) disable iff (!peripheral_sresetn_core)
        !(csr_req.wr_en && csr_req.rd_en)
    ) else $error("stats_csr_file: wr_en and rd_en high together");

    a_rd_valid_single: assert property (
        @(posedge clk_ifc) disable iff (!peripheral_sresetn_core)
        csr_rsp.rd_valid |=> !csr_rsp.rd_valid
    ) else $error("stats_csr_file: rd_valid high two cycles in a row");

endmodule
